// File: files.f
+incdir+verification
source/rv32i_pkg.sv
source/pc_gen.sv
source/inst_fetch.sv
source/decode.sv
source/alu.sv
source/commit.sv
source/core_top.sv
verification/core_tb.sv

// File: source/alu.sv
/*
 * execute stage
 * operand forwarding, arithmetic and compare, jump target
 * and the execute pipeline register
 */
`default_nettype none

module alu
    import rv32i_pkg::*;
(
    input  wire           CLK,
    input  wire           i_rst,
    input  wire           i_flush,
    input  wire word_t    i_d_pc,
    input  wire           i_d_valid,
    input  var opcode_e   i_d_opcode,
    input  var alu_op_e   i_d_alu_op,
    input  var br_cond_e  i_d_br_cond,
    input  wire word_t    i_d_imm,
    input  wire reg_idx_t i_d_rs1,
    input  wire word_t    i_d_rs1_v,
    input  wire reg_idx_t i_d_rs2,
    input  wire word_t    i_d_rs2_v,
    input  wire reg_idx_t i_d_rd,
    input  wire           i_m_valid,
    input  wire reg_idx_t i_m_rd,
    input  wire word_t    i_m_value,
    input  wire           i_w_valid,
    input  wire reg_idx_t i_w_rd,
    input  wire word_t    i_w_value,
    output word_t         o_a_pc,
    output logic          o_a_valid,
    output reg_idx_t      o_a_rd,
    output word_t         o_a_value,
    output logic          o_a_jump,
    output word_t         o_a_target
);

    word_t src1;
    word_t src2;
    word_t op_a;
    word_t op_b;
    word_t alu_res;
    word_t result;
    word_t target;
    logic  taken;
    logic  jump;

    // youngest producer wins, x0 is never forwarded
    // the own output register holds the instruction just ahead
    function automatic word_t fwd(input reg_idx_t idx, input word_t dec_v);
        if (idx == '0) begin
            return dec_v;
        end
        if (o_a_valid && o_a_rd == idx) begin
            return o_a_value;
        end
        if (i_m_valid && i_m_rd == idx) begin
            return i_m_value;
        end
        if (i_w_valid && i_w_rd == idx) begin
            return i_w_value;
        end
        return dec_v;
    endfunction

    // ------------------------------------------------------------------------
    // operands and arithmetic
    // ------------------------------------------------------------------------
    always_comb begin
        src1 = fwd(i_d_rs1, i_d_rs1_v);
        src2 = fwd(i_d_rs2, i_d_rs2_v);
        op_a = (i_d_opcode == OPC_AUIPC) ? i_d_pc : src1;
        op_b = (i_d_opcode == OPC_OP) ? src2 : i_d_imm;
        case (i_d_alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_b;
        endcase
    end

    // ------------------------------------------------------------------------
    // jumps and branches
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_d_br_cond)
            BR_BEQ:  taken = (src1 == src2);
            BR_BNE:  taken = (src1 != src2);
            BR_BLT:  taken = ($signed(src1) < $signed(src2));
            BR_BGE:  taken = ($signed(src1) >= $signed(src2));
            BR_BLTU: taken = (src1 < src2);
            BR_BGEU: taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase

        jump = (i_d_opcode == OPC_JAL) || (i_d_opcode == OPC_JALR) ||
               ((i_d_opcode == OPC_BRANCH) && taken);

        if (i_d_opcode == OPC_JALR) begin
            target = (src1 + i_d_imm) & ~32'd1;
        end else begin
            target = i_d_pc + i_d_imm;
        end

        // link address for both jump forms
        if (i_d_opcode == OPC_JAL || i_d_opcode == OPC_JALR) begin
            result = i_d_pc + 32'd4;
        end else begin
            result = alu_res;
        end
    end

    // execute pipeline register
    always_ff @(posedge CLK) begin
        if (i_rst) begin
            o_a_valid <= 1'b0;
        end else begin
            o_a_valid <= i_d_valid & ~i_flush;
        end
    end

    always_ff @(posedge CLK) begin
        o_a_pc     <= i_d_pc;
        o_a_rd     <= i_d_rd;
        o_a_value  <= result;
        o_a_jump   <= jump;
        o_a_target <= target;
    end

endmodule

`default_nettype wire

// File: source/commit.sv
/*
 * commit and writeback stage registers
 * resolves jumps into the flush and the redirect pc
 */
`default_nettype none

module commit
    import rv32i_pkg::*;
(
    input  wire           CLK,
    input  wire           i_rst,
    input  wire word_t    i_a_pc,
    input  wire           i_a_valid,
    input  wire reg_idx_t i_a_rd,
    input  wire word_t    i_a_value,
    input  wire           i_a_jump,
    input  wire word_t    i_a_target,
    output logic          o_m_valid,
    output reg_idx_t      o_m_rd,
    output word_t         o_m_value,
    output logic          o_w_valid,
    output reg_idx_t      o_w_rd,
    output word_t         o_w_value,
    output logic          o_flush,
    output word_t         o_new_pc
);

    logic m_jump;

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            o_m_valid <= 1'b0;
            o_w_valid <= 1'b0;
            m_jump    <= 1'b0;
        end else begin
            // the a slot is younger than a jump sitting in m
            o_m_valid <= i_a_valid & ~o_flush;
            o_w_valid <= o_m_valid;
            m_jump    <= i_a_jump;
        end
    end

    always_ff @(posedge CLK) begin
        o_m_rd    <= i_a_rd;
        o_m_value <= i_a_value;
        o_new_pc  <= i_a_target;
        o_w_rd    <= o_m_rd;
        o_w_value <= o_m_value;
    end

    assign o_flush = o_m_valid & m_jump;

endmodule

`default_nettype wire

// File: source/core_top.sv
/*
 * five-stage RV32I pipeline top level
 * pc, fetch, decode, execute and commit stages with the debug view
 */
`default_nettype none

module core_top
    import rv32i_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire           CLK,
    input  wire           i_rst,
    input  wire           i_exec,
    output word_t         o_imem_addr,
    input  wire word_t    i_imem_data,
    input  wire reg_idx_t i_dbg_sel,
    output word_t         o_dbg_data,
    output word_t         o_pc,
    output logic          o_flush
);

    // ------------------------------------------------------------------------
    // stage signals
    // ------------------------------------------------------------------------
    word_t    new_pc;
    logic     p_valid;

    word_t    f_pc;
    word_t    f_inst;
    logic     f_valid;

    word_t    d_pc;
    logic     d_valid;
    opcode_e  d_opcode;
    alu_op_e  d_alu_op;
    br_cond_e d_br_cond;
    word_t    d_imm;
    reg_idx_t d_rs1;
    word_t    d_rs1_v;
    reg_idx_t d_rs2;
    word_t    d_rs2_v;
    reg_idx_t d_rd;

    word_t    a_pc;
    logic     a_valid;
    reg_idx_t a_rd;
    word_t    a_value;
    logic     a_jump;
    word_t    a_target;

    logic     m_valid;
    reg_idx_t m_rd;
    word_t    m_value;
    logic     w_valid;
    reg_idx_t w_rd;
    word_t    w_value;

    // ------------------------------------------------------------------------
    // pipeline stages
    // ------------------------------------------------------------------------
    // o_pc and o_flush are taken straight from the stage outputs
    pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen (
        .CLK      (CLK),
        .i_rst    (i_rst),
        .i_exec   (i_exec),
        .i_flush  (o_flush),
        .i_new_pc (new_pc),
        .o_p_pc   (o_pc),
        .o_p_valid(p_valid)
    );

    inst_fetch inst_fetch (
        .CLK        (CLK),
        .i_rst      (i_rst),
        .i_flush    (o_flush),
        .i_p_pc     (o_pc),
        .i_p_valid  (p_valid),
        .i_imem_data(i_imem_data),
        .o_imem_addr(o_imem_addr),
        .o_f_pc     (f_pc),
        .o_f_inst   (f_inst),
        .o_f_valid  (f_valid)
    );

    decode decode (
        .CLK        (CLK),
        .i_rst      (i_rst),
        .i_flush    (o_flush),
        .i_f_pc     (f_pc),
        .i_f_inst   (f_inst),
        .i_f_valid  (f_valid),
        .i_m_valid  (m_valid),
        .i_m_rd     (m_rd),
        .i_m_value  (m_value),
        .i_dbg_sel  (i_dbg_sel),
        .o_dbg_data (o_dbg_data),
        .o_d_pc     (d_pc),
        .o_d_valid  (d_valid),
        .o_d_opcode (d_opcode),
        .o_d_alu_op (d_alu_op),
        .o_d_br_cond(d_br_cond),
        .o_d_imm    (d_imm),
        .o_d_rs1    (d_rs1),
        .o_d_rs1_v  (d_rs1_v),
        .o_d_rs2    (d_rs2),
        .o_d_rs2_v  (d_rs2_v),
        .o_d_rd     (d_rd)
    );

    alu alu (
        .CLK        (CLK),
        .i_rst      (i_rst),
        .i_flush    (o_flush),
        .i_d_pc     (d_pc),
        .i_d_valid  (d_valid),
        .i_d_opcode (d_opcode),
        .i_d_alu_op (d_alu_op),
        .i_d_br_cond(d_br_cond),
        .i_d_imm    (d_imm),
        .i_d_rs1    (d_rs1),
        .i_d_rs1_v  (d_rs1_v),
        .i_d_rs2    (d_rs2),
        .i_d_rs2_v  (d_rs2_v),
        .i_d_rd     (d_rd),
        .i_m_valid  (m_valid),
        .i_m_rd     (m_rd),
        .i_m_value  (m_value),
        .i_w_valid  (w_valid),
        .i_w_rd     (w_rd),
        .i_w_value  (w_value),
        .o_a_pc     (a_pc),
        .o_a_valid  (a_valid),
        .o_a_rd     (a_rd),
        .o_a_value  (a_value),
        .o_a_jump   (a_jump),
        .o_a_target (a_target)
    );

    commit commit (
        .CLK       (CLK),
        .i_rst     (i_rst),
        .i_a_pc    (a_pc),
        .i_a_valid (a_valid),
        .i_a_rd    (a_rd),
        .i_a_value (a_value),
        .i_a_jump  (a_jump),
        .i_a_target(a_target),
        .o_m_valid (m_valid),
        .o_m_rd    (m_rd),
        .o_m_value (m_value),
        .o_w_valid (w_valid),
        .o_w_rd    (w_rd),
        .o_w_value (w_value),
        .o_flush   (o_flush),
        .o_new_pc  (new_pc)
    );

endmodule

`default_nettype wire

// File: source/decode.sv
/*
 * decode stage
 * field split, immediates, ALU operation select,
 * register file with commit bypass and the decode pipeline register
 */
`default_nettype none

module decode
    import rv32i_pkg::*;
(
    input  wire           CLK,
    input  wire           i_rst,
    input  wire           i_flush,
    input  wire word_t    i_f_pc,
    input  wire word_t    i_f_inst,
    input  wire           i_f_valid,
    input  wire           i_m_valid,
    input  wire reg_idx_t i_m_rd,
    input  wire word_t    i_m_value,
    input  wire reg_idx_t i_dbg_sel,
    output word_t         o_dbg_data,
    output word_t         o_d_pc,
    output logic          o_d_valid,
    output opcode_e       o_d_opcode,
    output alu_op_e       o_d_alu_op,
    output br_cond_e      o_d_br_cond,
    output word_t         o_d_imm,
    output reg_idx_t      o_d_rs1,
    output word_t         o_d_rs1_v,
    output reg_idx_t      o_d_rs2,
    output word_t         o_d_rs2_v,
    output reg_idx_t      o_d_rd
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       known;
    word_t      imm;
    alu_op_e    alu_op;
    word_t      rs1_v;
    word_t      rs2_v;
    word_t      rf [1:31];

    // funct3 decode shared by OP and OP-IMM
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // field extraction and immediates
    // ------------------------------------------------------------------------
    assign opcode   = opcode_e'(i_f_inst[6:0]);
    assign funct3   = i_f_inst[14:12];
    assign funct7_5 = i_f_inst[30];
    assign rs1      = i_f_inst[19:15];
    assign rs2      = i_f_inst[24:20];

    always_comb begin
        known  = 1'b1;
        alu_op = ALU_ADD;
        imm    = {{20{i_f_inst[31]}}, i_f_inst[31:20]};
        case (opcode)
            OPC_OP: begin
                alu_op = arith_op(funct3, funct7_5);
            end
            OPC_OP_IMM: begin
                // bit 30 only selects SRAI, ADDI has no subtract form
                alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7_5);
            end
            OPC_LUI: begin
                imm    = {i_f_inst[31:12], 12'b0};
                alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                imm = {i_f_inst[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm = {{11{i_f_inst[31]}}, i_f_inst[31], i_f_inst[19:12],
                       i_f_inst[20], i_f_inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                imm = {{20{i_f_inst[31]}}, i_f_inst[31:20]};
            end
            OPC_BRANCH: begin
                imm = {{19{i_f_inst[31]}}, i_f_inst[31], i_f_inst[7],
                       i_f_inst[30:25], i_f_inst[11:8], 1'b0};
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    // branches and unknown opcodes write nothing
    assign rd = (!known || opcode == OPC_BRANCH) ? '0 : i_f_inst[11:7];

    // ------------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (i_m_valid && i_m_rd != '0) begin
            rf[i_m_rd] <= i_m_value;
        end
    end

    // m stage writes this edge, so pass it through
    always_comb begin
        rs1_v = (rs1 == '0) ? '0 : rf[rs1];
        rs2_v = (rs2 == '0) ? '0 : rf[rs2];
        if (i_m_valid && i_m_rd == rs1 && rs1 != '0) begin
            rs1_v = i_m_value;
        end
        if (i_m_valid && i_m_rd == rs2 && rs2 != '0) begin
            rs2_v = i_m_value;
        end
    end

    assign o_dbg_data = (i_dbg_sel == '0) ? '0 : rf[i_dbg_sel];

    // decode pipeline register
    always_ff @(posedge CLK) begin
        if (i_rst) begin
            o_d_valid <= 1'b0;
        end else begin
            o_d_valid <= i_f_valid & known & ~i_flush;
        end
    end

    always_ff @(posedge CLK) begin
        o_d_pc      <= i_f_pc;
        o_d_opcode  <= opcode;
        o_d_alu_op  <= alu_op;
        o_d_br_cond <= br_cond_e'(funct3);
        o_d_imm     <= imm;
        o_d_rs1     <= rs1;
        o_d_rs1_v   <= rs1_v;
        o_d_rs2     <= rs2;
        o_d_rs2_v   <= rs2_v;
        o_d_rd      <= rd;
    end

endmodule

`default_nettype wire

// File: source/inst_fetch.sv
/*
 * instruction fetch stage
 * drives the memory address and aligns pc and valid with the returned word
 */
`default_nettype none

module inst_fetch
    import rv32i_pkg::*;
(
    input  wire        CLK,
    input  wire        i_rst,
    input  wire        i_flush,
    input  wire word_t i_p_pc,
    input  wire        i_p_valid,
    input  wire word_t i_imem_data,
    output word_t      o_imem_addr,
    output word_t      o_f_pc,
    output word_t      o_f_inst,
    output logic       o_f_valid
);

    logic f_valid_q;

    // memory answers one cycle after the address
    assign o_imem_addr = i_p_pc;

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            f_valid_q <= 1'b0;
        end else begin
            f_valid_q <= i_p_valid & ~i_flush;
        end
    end

    always_ff @(posedge CLK) begin
        o_f_pc <= i_p_pc;
    end

    // squashed or empty slots decode as a NOP
    assign o_f_valid = f_valid_q & ~i_flush;
    assign o_f_inst  = o_f_valid ? i_imem_data : NOP_INST;

endmodule

`default_nettype wire

// File: source/pc_gen.sv
/*
 * program counter with run control and flush redirect
 */
`default_nettype none

module pc_gen
    import rv32i_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire        CLK,
    input  wire        i_rst,
    input  wire        i_exec,
    input  wire        i_flush,
    input  wire word_t i_new_pc,
    output word_t      o_p_pc,
    output logic       o_p_valid
);

    always_ff @(posedge CLK) begin
        if (i_rst) begin
            o_p_pc <= RESET_PC;
        end else begin
            // step past an address only once it has been issued
            if (i_flush) begin
                o_p_pc <= i_new_pc;
            end else if (o_p_valid) begin
                o_p_pc <= o_p_pc + 32'd4;
            end
        end
    end

    // the address on the wrong path is dropped in its own cycle
    assign o_p_valid = i_exec & ~i_flush;

endmodule

`default_nettype wire

// File: source/rv32i_pkg.sv
/*
 * shared RV32I core definitions
 * data word and register index types, major opcodes,
 * ALU operations, branch conditions and the canonical NOP
 */
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // encoded as funct3 of the branch
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_e;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// File: verification/program_table.svh
/*
 * test program table for the core testbench
 * instruction encoders, program words, halt address, first jump and the
 * register values expected once each program has run
 */
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

localparam int NUM_PROGS  = 6;
localparam int MAX_INSTS  = 16;
localparam int MAX_CHECKS = 10;

localparam logic [2:0] F3_ADD  = 3'b000;
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;
localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_ALT  = 7'b0100000;

word_t    prog_inst [NUM_PROGS][MAX_INSTS];
int       prog_len  [NUM_PROGS];
word_t    halt_addr [NUM_PROGS];
int       first_jump [NUM_PROGS];
reg_idx_t chk_reg   [NUM_PROGS][MAX_CHECKS];
word_t    chk_exp   [NUM_PROGS][MAX_CHECKS];
int       chk_count [NUM_PROGS];

// ---------------------------------------------------------------------------
// RV32I instruction formats
// ---------------------------------------------------------------------------
function automatic word_t rtype(input logic [6:0] f7, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3,
                                input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t itype(input opcode_e opc, input reg_idx_t rd,
                                input logic [2:0] f3, input reg_idx_t rs1,
                                input int imm);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic word_t utype(input opcode_e opc, input reg_idx_t rd, input int imm20);
    return {imm20[19:0], rd, opc};
endfunction

// offsets are byte offsets from the jump's own address
function automatic word_t jtype(input reg_idx_t rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic word_t btype(input br_cond_e cond, input reg_idx_t rs1,
                                input reg_idx_t rs2, input int off);
    return {off[12], off[10:5], rs2, rs1, cond, off[4:1], off[11], OPC_BRANCH};
endfunction

task automatic put_inst(input int p, input word_t inst);
    prog_inst[p][prog_len[p]] = inst;
    prog_len[p]++;
endtask

// index of the first taken jump, reference for the flush timing
task automatic mark_jump(input int p);
    if (first_jump[p] < 0) begin
        first_jump[p] = prog_len[p];
    end
endtask

// jal x0, 0 spins on its own address
task automatic put_halt(input int p);
    halt_addr[p] = word_t'(prog_len[p] * 4);
    mark_jump(p);
    put_inst(p, jtype(0, 0));
endtask

task automatic expect_reg(input int p, input reg_idx_t r, input word_t v);
    chk_reg[p][chk_count[p]] = r;
    chk_exp[p][chk_count[p]] = v;
    chk_count[p]++;
endtask

task automatic fill_table();
    for (int p = 0; p < NUM_PROGS; p++) begin
        prog_len[p]   = 0;
        chk_count[p]  = 0;
        first_jump[p] = -1;
    end

    // dependent chain at distances 1 to 3
    put_inst(0, itype(OPC_OP_IMM, 1, F3_ADD, 0, 5));
    put_inst(0, itype(OPC_OP_IMM, 2, F3_ADD, 1, -12));
    put_inst(0, rtype(F7_BASE, 1, 2, F3_ADD, 3));
    put_inst(0, rtype(F7_ALT, 2, 3, F3_ADD, 4));
    put_inst(0, rtype(F7_BASE, 3, 4, F3_XOR, 5));
    put_inst(0, rtype(F7_BASE, 3, 5, F3_ADD, 6));
    put_inst(0, rtype(F7_ALT, 6, 1, F3_ADD, 7));
    put_inst(0, rtype(F7_BASE, 7, 7, F3_ADD, 8));
    put_inst(0, rtype(F7_ALT, 8, 0, F3_ADD, 9));
    put_halt(0);
    expect_reg(0, 1, 32'h0000_0005);
    expect_reg(0, 2, 32'hFFFF_FFF9);
    expect_reg(0, 3, 32'hFFFF_FFFE);
    expect_reg(0, 4, 32'h0000_0005);
    expect_reg(0, 5, 32'hFFFF_FFFB);
    expect_reg(0, 6, 32'hFFFF_FFF9);
    expect_reg(0, 7, 32'h0000_000C);
    expect_reg(0, 8, 32'h0000_0018);
    expect_reg(0, 9, 32'hFFFF_FFE8);

    // shifts and compares on a negative value, then two LUI constants
    put_inst(1, itype(OPC_OP_IMM, 1, F3_ADD, 0, -16));
    put_inst(1, itype(OPC_OP_IMM, 2, F3_SLL, 1, 4));
    put_inst(1, itype(OPC_OP_IMM, 3, F3_SR, 1, 28));
    put_inst(1, itype(OPC_OP_IMM, 4, F3_SR, 1, 'h402));
    put_inst(1, itype(OPC_OP_IMM, 5, F3_ADD, 0, 3));
    put_inst(1, rtype(F7_BASE, 5, 1, F3_SLT, 6));
    put_inst(1, rtype(F7_BASE, 5, 1, F3_SLTU, 7));
    put_inst(1, utype(OPC_LUI, 8, 'h12345));
    put_inst(1, itype(OPC_OP_IMM, 8, F3_ADD, 8, 'h678));
    put_inst(1, utype(OPC_LUI, 9, 'hDEADC));
    put_inst(1, itype(OPC_OP_IMM, 9, F3_ADD, 9, -273));
    put_inst(1, rtype(F7_BASE, 1, 5, F3_SLTU, 10));
    put_halt(1);
    expect_reg(1, 1, 32'hFFFF_FFF0);
    expect_reg(1, 2, 32'hFFFF_FF00);
    expect_reg(1, 3, 32'h0000_000F);
    expect_reg(1, 4, 32'hFFFF_FFFC);
    expect_reg(1, 6, 32'h0000_0001);
    expect_reg(1, 7, 32'h0000_0000);
    expect_reg(1, 8, 32'h1234_5678);
    expect_reg(1, 9, 32'hDEAD_BEEF);
    expect_reg(1, 10, 32'h0000_0001);

    // taken beq skips three writes, not-taken bne falls through
    put_inst(2, itype(OPC_OP_IMM, 1, F3_ADD, 0, 7));
    put_inst(2, itype(OPC_OP_IMM, 2, F3_ADD, 0, 7));
    mark_jump(2);
    put_inst(2, btype(BR_BEQ, 1, 2, 16));
    put_inst(2, itype(OPC_OP_IMM, 3, F3_ADD, 0, 1));
    put_inst(2, itype(OPC_OP_IMM, 4, F3_ADD, 0, 2));
    put_inst(2, itype(OPC_OP_IMM, 5, F3_ADD, 0, 3));
    put_inst(2, itype(OPC_OP_IMM, 6, F3_ADD, 0, 4));
    put_inst(2, btype(BR_BNE, 1, 2, 8));
    put_inst(2, itype(OPC_OP_IMM, 7, F3_ADD, 0, 5));
    put_inst(2, itype(OPC_OP_IMM, 8, F3_ADD, 6, 1));
    put_halt(2);
    expect_reg(2, 1, 32'h0000_0007);
    expect_reg(2, 3, 32'h0000_0000);
    expect_reg(2, 4, 32'h0000_0000);
    expect_reg(2, 5, 32'h0000_0000);
    expect_reg(2, 6, 32'h0000_0004);
    expect_reg(2, 7, 32'h0000_0005);
    expect_reg(2, 8, 32'h0000_0005);

    // jal to 16, then jalr to (28 + 5) with bit 0 cleared
    put_inst(3, itype(OPC_OP_IMM, 1, F3_ADD, 0, 1));
    mark_jump(3);
    put_inst(3, jtype(2, 12));
    put_inst(3, itype(OPC_OP_IMM, 3, F3_ADD, 0, 9));
    put_inst(3, itype(OPC_OP_IMM, 3, F3_ADD, 0, 10));
    put_inst(3, itype(OPC_OP_IMM, 4, F3_ADD, 2, 20));
    put_inst(3, itype(OPC_JALR, 5, F3_ADD, 4, 5));
    put_inst(3, itype(OPC_OP_IMM, 6, F3_ADD, 0, 11));
    put_inst(3, itype(OPC_OP_IMM, 6, F3_ADD, 0, 12));
    put_inst(3, itype(OPC_OP_IMM, 7, F3_ADD, 5, 1));
    put_halt(3);
    expect_reg(3, 1, 32'h0000_0001);
    expect_reg(3, 2, 32'h0000_0008);
    expect_reg(3, 3, 32'h0000_0000);
    expect_reg(3, 4, 32'h0000_001C);
    expect_reg(3, 5, 32'h0000_0018);
    expect_reg(3, 6, 32'h0000_0000);
    expect_reg(3, 7, 32'h0000_0019);

    // x0 as destination of addi, lui and add
    put_inst(4, itype(OPC_OP_IMM, 0, F3_ADD, 0, 123));
    put_inst(4, rtype(F7_BASE, 0, 0, F3_ADD, 1));
    put_inst(4, utype(OPC_LUI, 0, 'hABCDE));
    put_inst(4, itype(OPC_OP_IMM, 2, F3_ADD, 0, 5));
    put_inst(4, itype(OPC_OP_IMM, 3, F3_ADD, 0, -1));
    put_inst(4, rtype(F7_BASE, 3, 3, F3_ADD, 0));
    put_inst(4, rtype(F7_BASE, 2, 0, F3_ADD, 4));
    put_halt(4);
    expect_reg(4, 0, 32'h0000_0000);
    expect_reg(4, 1, 32'h0000_0000);
    expect_reg(4, 2, 32'h0000_0005);
    expect_reg(4, 3, 32'hFFFF_FFFF);
    expect_reg(4, 4, 32'h0000_0005);

    // words behind the halt loop must never commit
    put_inst(5, itype(OPC_OP_IMM, 1, F3_ADD, 0, 1));
    put_inst(5, itype(OPC_OP_IMM, 1, F3_ADD, 1, 1));
    put_halt(5);
    put_inst(5, itype(OPC_OP_IMM, 2, F3_ADD, 0, 99));
    put_inst(5, itype(OPC_OP_IMM, 3, F3_ADD, 0, 77));
    put_inst(5, itype(OPC_OP_IMM, 1, F3_ADD, 0, 0));
    expect_reg(5, 1, 32'h0000_0002);
    expect_reg(5, 2, 32'h0000_0000);
    expect_reg(5, 3, 32'h0000_0000);
endtask

`endif

// File: verification/core_tb.sv
/*
 * testbench for the five-stage RV32I core
 * clock, reset, instruction memory model, program run loop,
 * compare tasks and the cycle timeout
 */
`default_nettype none

module core_tb
    import rv32i_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_WORDS   = 64;
    localparam int RUN_CYCLES   = 40;
    localparam int DRAIN_CYCLES = 8;

    logic     clk = 1'b0;
    logic     rst;
    logic     exec;
    reg_idx_t dbg_sel;
    word_t    imem_addr;
    word_t    imem_data = NOP_INST;
    word_t    dbg_data;
    word_t    pc;
    logic     flush;

    word_t    imem [IMEM_WORDS];
    int       reg_errors = 0;
    int       pc_errors = 0;
    int       flush_errors = 0;
    int       cur_prog = 0;

    `include "program_table.svh"

    localparam int CYCLE_LIMIT = NUM_PROGS * 60 + 100;

    core_top #(
        .RESET_PC   (32'h0000_0000)
    ) dut_i (
        .CLK        (clk),
        .i_rst      (rst),
        .i_exec     (exec),
        .o_imem_addr(imem_addr),
        .i_imem_data(imem_data),
        .i_dbg_sel  (dbg_sel),
        .o_dbg_data (dbg_data),
        .o_pc       (pc),
        .o_flush    (flush)
    );

    always #2 clk = ~clk;

    // instruction memory, word returned one cycle after its address
    always @(posedge clk) begin
        if (imem_addr < word_t'(IMEM_WORDS * 4)) begin
            imem_data <= imem[imem_addr[7:2]];
        end else begin
            imem_data <= NOP_INST;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_reg(input reg_idx_t idx, input word_t got, input word_t exp);
        if (got !== exp) begin
            reg_errors++;
            $display("error at %0t: program %0d x%0d is 0x%08h, expected 0x%08h",
                     $time, cur_prog, idx, got, exp);
        end
    endtask

    task automatic check_pc(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            pc_errors++;
            $display("error at %0t: program %0d %s pc is 0x%08h, expected 0x%08h",
                     $time, cur_prog, what, got, exp);
        end
    endtask

    task automatic check_flush(input int cycle, input logic got, input logic exp);
        if (got !== exp) begin
            flush_errors++;
            $display("error at %0t: program %0d flush is %0b in run cycle %0d, expected %0b",
                     $time, cur_prog, got, cycle, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // program run
    // ------------------------------------------------------------------------
    task automatic load_program(input int p);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP_INST;
        end
        for (int i = 0; i < prog_len[p]; i++) begin
            imem[i] = prog_inst[p][i];
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst  <= 1'b1;
        exec <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_program(input int p);
        word_t pc_settled;
        word_t pc_later;
        int    flush_at;
        cur_prog = p;
        flush_at = first_jump[p] + 4;
        load_program(p);
        reset_core();
        @(posedge clk);
        exec <= 1'b1;

        // issue starts with exec, the first jump flushes four cycles later
        // for exactly one cycle
        for (int n = 0; n < RUN_CYCLES; n++) begin
            @(negedge clk);
            if (n <= flush_at + 4) begin
                check_flush(n, flush, n == flush_at);
            end
            @(posedge clk);
        end
        exec <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);

        // halted core must park on the loop and stay there
        @(negedge clk);
        pc_settled = pc;
        repeat (3) @(negedge clk);
        pc_later = pc;
        check_pc("halt", pc_settled, halt_addr[p]);
        check_pc("drained", pc_later, halt_addr[p]);

        for (int k = 0; k < chk_count[p]; k++) begin
            @(posedge clk);
            dbg_sel <= chk_reg[p][k];
            @(negedge clk);
            check_reg(chk_reg[p][k], dbg_data, chk_exp[p][k]);
        end
    endtask

    initial begin
        rst     = 1'b1;
        exec    = 1'b0;
        dbg_sel = '0;
        fill_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("checks done: %0d register errors, %0d pc errors, %0d flush errors",
                 reg_errors, pc_errors, flush_errors);
        if (reg_errors == 0 && pc_errors == 0 && flush_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // run limit
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
